// ==== verilog/pkt_buf_pkg.sv ====
// ======================================================================
// Packet buffer types: FIFO line, control word, status word, FSM states
// ======================================================================

package pkt_buf_pkg;

   // One 36-bit FIFO line, flags above the data word
   typedef struct packed {
      logic [1:0]  occ;       // Occupancy of last word, unused here
      logic        eop;       // End of packet
      logic        sop;       // Start of packet
      logic [31:0] data;
   } fifo_line_t;

   // Control word written over the settings bus
   typedef struct packed {
      logic [15:0] length;    // Words to stream out on a read
      logic [11:0] rsvd;
      logic        read;      // Start read machine
      logic        rd_clear;  // Force read machine to idle
      logic        write;     // Start write machine
      logic        wr_clear;  // Force write machine to idle
   } buf_ctrl_t;

   // Status word seen by the CPU
   typedef struct packed {
      logic [15:0] wr_addr;   // Words taken in, not clipped
      logic [8:0]  rsvd_hi;
      logic        rd_idle;
      logic        rd_error;
      logic        rd_done;
      logic        rsvd_lo;
      logic        wr_idle;
      logic        wr_error;
      logic        wr_done;
   } buf_status_t;

   // Shared by both machines, each uses a subset
   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      PRE_READ = 3'd1,
      READING  = 3'd2,
      WRITING  = 3'd3,
      ERROR    = 3'd4,
      DONE     = 3'd5
   } buf_state_e;

endpackage

// ==== verilog/setting_reg.sv ====
// ======================================================================
// Settings bus register with one-cycle change pulse
// ======================================================================
`timescale 1ns/1ps

module setting_reg
  #(parameter logic [7:0] BASE = 8'd0)
   (input  logic                   clk,
    input  logic                   wb_rst_i,
    input  logic                   set_stb_i,
    input  logic [7:0]             set_addr_i,
    input  logic [31:0]            set_data_i,
    output pkt_buf_pkg::buf_ctrl_t ctrl_o,
    output logic                   changed_o);

   import pkt_buf_pkg::*;

   logic hit;

   assign hit = set_stb_i && (set_addr_i == BASE);   // Strobe at our address

   always_ff @(posedge clk)
   begin
      if (wb_rst_i)
      begin
         ctrl_o    <= '0;
         changed_o <= 1'b0;
      end
      else
      begin
         changed_o <= hit;                            // High for exactly one cycle
         if (hit)
            ctrl_o <= buf_ctrl_t'(set_data_i);
      end
   end

endmodule

// ==== verilog/ram_2port.sv ====
// ======================================================================
// True dual-port synchronous RAM, read-first on both ports
// ======================================================================
`timescale 1ns/1ps

module ram_2port
  #(parameter int DWIDTH = 32,
    parameter int AWIDTH = 9)
   (input  logic              clk,
    input  logic              ena_i, wea_i,
    input  logic [AWIDTH-1:0] addra_i,
    input  logic [DWIDTH-1:0] dia_i,
    output logic [DWIDTH-1:0] doa_o,
    input  logic              enb_i, web_i,
    input  logic [AWIDTH-1:0] addrb_i,
    input  logic [DWIDTH-1:0] dib_i,
    output logic [DWIDTH-1:0] dob_o);

   logic [DWIDTH-1:0] mem [0:(1<<AWIDTH)-1];

   always_ff @(posedge clk)
   begin
      if (ena_i)
      begin
         if (wea_i) mem[addra_i] <= dia_i;
         doa_o <= mem[addra_i];   // Old contents on a write
      end
      if (enb_i)
      begin
         if (web_i) mem[addrb_i] <= dib_i;
         dob_o <= mem[addrb_i];
      end
   end

   // Port b would silently win, so flag the collision
   a_no_write_collision : assert property (@(posedge clk)
      !(ena_i && wea_i && enb_i && web_i && (addra_i == addrb_i)))
      else $error("ram_2port: both ports write address %0h", addra_i);

endmodule

// ==== verilog/buf_write_fsm.sv ====
// ======================================================================
// Write machine: FIFO lines into the in-buffer, address clipped at top
// ======================================================================
`timescale 1ns/1ps

module buf_write_fsm
  #(parameter int BUF_SIZE = 9)
   (input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic                    go_i,
    input  pkt_buf_pkg::buf_ctrl_t  ctrl_i,
    input  pkt_buf_pkg::fifo_line_t wr_line_i,
    input  logic                    wr_ready_i,
    output logic                    wr_ready_o,
    output logic                    ram_we_o,
    output logic [BUF_SIZE-1:0]     ram_addr_o,
    output logic [15:0]             wr_addr_o,
    output logic                    idle_o,
    output logic                    done_o,
    output logic                    error_o);

   import pkt_buf_pkg::*;

   buf_state_e  wr_state;
   logic [15:0] wr_addr;   // May run past the buffer on long packets

   always_ff @(posedge clk)
   begin
      if (wb_rst_i)
      begin
         wr_state <= IDLE;
         wr_addr  <= 16'd0;
      end
      else if (go_i && ctrl_i.wr_clear)
         wr_state <= IDLE;   // Clear wins over a start in the same word
      else
         case (wr_state)
            IDLE    : if (go_i && ctrl_i.write)
                      begin
                         wr_addr  <= 16'd0;
                         wr_state <= WRITING;
                      end
            WRITING : if (wr_ready_i)
                      begin
                         wr_addr <= wr_addr + 16'd1;
                         if (wr_line_i.sop && wr_line_i.eop)
                            wr_state <= ERROR;   // Single-line packet
                         else if (wr_line_i.eop)
                            wr_state <= DONE;
                      end
            default : wr_state <= wr_state;      // DONE and ERROR wait for a clear
         endcase
   end

   assign wr_ready_o = (wr_state == WRITING);
   assign ram_we_o   = wr_ready_o && wr_ready_i;   // Store in the accept cycle
   // Any bit past the buffer pins writes to the top word
   assign ram_addr_o = (|wr_addr[15:BUF_SIZE]) ? {BUF_SIZE{1'b1}} : wr_addr[BUF_SIZE-1:0];
   assign wr_addr_o  = wr_addr;
   assign idle_o     = (wr_state == IDLE);
   assign done_o     = (wr_state == DONE);
   assign error_o    = (wr_state == ERROR);

   // Ready only ever comes up through a start from idle
   a_ready_from_start : assert property (@(posedge clk) disable iff (wb_rst_i)
      $rose(wr_ready_o) |-> $past(go_i && ctrl_i.write && wr_state == IDLE))
      else $error("buf_write_fsm: wr_ready_o rose without a write start");

endmodule

// ==== verilog/buf_ram_bank.sv ====
// ======================================================================
// In and out buffer RAMs with the Wishbone slave port
// ======================================================================
`timescale 1ns/1ps

module buf_ram_bank
  #(parameter int BUF_SIZE = 9)
   (input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [15:0]             wb_adr_i,
    input  logic [31:0]             wb_dat_i,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o,
    input  logic                    in_we_i,
    input  logic [BUF_SIZE-1:0]     in_addr_i,
    input  pkt_buf_pkg::fifo_line_t in_data_i,
    input  logic                    out_en_i,
    input  logic [BUF_SIZE-1:0]     out_addr_i,
    output logic [31:0]             out_data_o);

   logic [BUF_SIZE-1:0] cpu_addr;

   assign cpu_addr = wb_adr_i[BUF_SIZE+1:2];   // Byte address to word index

   // CPU reads here, write machine fills it
   ram_2port #(.DWIDTH(32), .AWIDTH(BUF_SIZE)) u_buffer_in
     (.clk(clk),
      .ena_i(wb_stb_i), .wea_i(1'b0), .addra_i(cpu_addr), .dia_i(32'd0), .doa_o(wb_dat_o),
      .enb_i(in_we_i), .web_i(in_we_i), .addrb_i(in_addr_i), .dib_i(in_data_i.data),
      .dob_o());

   // CPU writes here, read machine drains it
   ram_2port #(.DWIDTH(32), .AWIDTH(BUF_SIZE)) u_buffer_out
     (.clk(clk),
      .ena_i(wb_stb_i), .wea_i(wb_we_i), .addra_i(cpu_addr), .dia_i(wb_dat_i), .doa_o(),
      .enb_i(out_en_i), .web_i(1'b0), .addrb_i(out_addr_i), .dib_i(32'd0),
      .dob_o(out_data_o));

   // Single-cycle ack, lines up with registered RAM data
   always_ff @(posedge clk)
   begin
      if (wb_rst_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= wb_stb_i && !wb_ack_o;
   end

   a_ack_single : assert property (@(posedge clk) disable iff (wb_rst_i)
      wb_ack_o |=> !wb_ack_o)
      else $error("buf_ram_bank: wb_ack_o held for two cycles");

endmodule

// ==== verilog/buf_read_fsm.sv ====
// ======================================================================
// Read machine: out-buffer streamed as framed FIFO lines
// ======================================================================
`timescale 1ns/1ps

module buf_read_fsm
  #(parameter int BUF_SIZE = 9)
   (input  logic                    clk,
    input  logic                    wb_rst_i,
    input  logic                    go_i,
    input  pkt_buf_pkg::buf_ctrl_t  ctrl_i,
    input  logic [31:0]             rd_data_i,
    output pkt_buf_pkg::fifo_line_t rd_line_o,
    output logic                    rd_ready_o,
    input  logic                    rd_ready_i,
    output logic                    ram_en_o,
    output logic [BUF_SIZE-1:0]     ram_addr_o,
    output logic                    idle_o,
    output logic                    done_o,
    output logic                    error_o);

   import pkt_buf_pkg::*;

   buf_state_e  rd_state;
   logic [15:0] rd_addr;      // One word ahead of the presented line
   logic [15:0] rd_addr_next;
   logic [15:0] rd_length;    // Latched at start
   logic        rd_sop, rd_eop;

   assign rd_addr_next = rd_addr + 16'd1;

   always_ff @(posedge clk)
   begin
      if (wb_rst_i || (go_i && ctrl_i.rd_clear))
      begin
         rd_state <= IDLE;
         rd_addr  <= 16'd0;
         rd_sop   <= 1'b0;
         rd_eop   <= 1'b0;
      end
      else
         case (rd_state)
            IDLE     : if (go_i && ctrl_i.read)
                       begin
                          rd_addr   <= 16'd0;
                          rd_length <= ctrl_i.length;
                          rd_state  <= PRE_READ;
                       end
            PRE_READ :   // Word 0 is being fetched this cycle
                       begin
                          rd_addr  <= rd_addr_next;
                          rd_sop   <= 1'b1;
                          rd_eop   <= (rd_length == 16'd1);   // One-word read
                          rd_state <= READING;
                       end
            READING  : if (rd_ready_i)
                       begin
                          rd_sop  <= 1'b0;
                          rd_addr <= rd_addr_next;
                          rd_eop  <= (rd_addr_next == rd_length);
                          if (rd_eop)
                             rd_state <= DONE;   // Last line just went out
                       end
            default  : rd_state <= rd_state;
         endcase
   end

   // No occupancy generated on this side
   assign rd_line_o  = '{occ: 2'b00, eop: rd_eop, sop: rd_sop, data: rd_data_i};
   assign rd_ready_o = (rd_state == READING);
   assign ram_en_o   = !(rd_ready_o && !rd_ready_i);   // Hold RAM output under stall
   assign ram_addr_o = rd_addr[BUF_SIZE-1:0];
   assign idle_o     = (rd_state == IDLE);
   assign done_o     = (rd_state == DONE);
   assign error_o    = (rd_state == ERROR);           // Kept for status, never entered

   // Sink stall must not move the presented line
   a_line_hold : assert property (@(posedge clk) disable iff (wb_rst_i)
      (rd_ready_o && !rd_ready_i && !(go_i && ctrl_i.rd_clear)) |=> $stable(rd_line_o))
      else $error("buf_read_fsm: rd_line_o changed during back-pressure");

endmodule

// ==== verilog/pkt_buf_top.sv ====
// ======================================================================
// Packet buffer top: settings, write and read machines, RAM bank
// ======================================================================
`timescale 1ns/1ps

module pkt_buf_top
  #(parameter logic [7:0] BASE     = 8'd0,
    parameter int         BUF_SIZE = 9)
   (input  logic                      clk,
    input  logic                      wb_rst_i,
    input  logic                      set_stb_i,
    input  logic [7:0]                set_addr_i,
    input  logic [31:0]               set_data_i,
    output pkt_buf_pkg::buf_status_t  status_o,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [15:0]               wb_adr_i,
    input  logic [31:0]               wb_dat_i,
    output logic [31:0]               wb_dat_o,
    output logic                      wb_ack_o,
    input  pkt_buf_pkg::fifo_line_t   wr_line_i,
    input  logic                      wr_ready_i,
    output logic                      wr_ready_o,
    output pkt_buf_pkg::fifo_line_t   rd_line_o,
    output logic                      rd_ready_o,
    input  logic                      rd_ready_i);

   import pkt_buf_pkg::*;

   buf_ctrl_t           ctrl;
   logic                go;                       // Control word just written
   logic                wr_we;
   logic [BUF_SIZE-1:0] wr_ram_addr;              // Clipped
   logic [15:0]         wr_addr;                  // Raw count for status
   logic                wr_idle, wr_done, wr_error;
   logic                rd_en;
   logic [BUF_SIZE-1:0] rd_ram_addr;
   logic [31:0]         rd_data;
   logic                rd_idle, rd_done, rd_error;

   setting_reg #(.BASE(BASE)) u_sreg
     (.clk(clk), .wb_rst_i(wb_rst_i), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .ctrl_o(ctrl), .changed_o(go));

   buf_write_fsm #(.BUF_SIZE(BUF_SIZE)) u_write
     (.clk(clk), .wb_rst_i(wb_rst_i), .go_i(go), .ctrl_i(ctrl), .wr_line_i(wr_line_i),
      .wr_ready_i(wr_ready_i), .wr_ready_o(wr_ready_o), .ram_we_o(wr_we),
      .ram_addr_o(wr_ram_addr), .wr_addr_o(wr_addr),
      .idle_o(wr_idle), .done_o(wr_done), .error_o(wr_error));

   buf_ram_bank #(.BUF_SIZE(BUF_SIZE)) u_bank
     (.clk(clk), .wb_rst_i(wb_rst_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .in_we_i(wr_we), .in_addr_i(wr_ram_addr), .in_data_i(wr_line_i),
      .out_en_i(rd_en), .out_addr_i(rd_ram_addr), .out_data_o(rd_data));

   buf_read_fsm #(.BUF_SIZE(BUF_SIZE)) u_read
     (.clk(clk), .wb_rst_i(wb_rst_i), .go_i(go), .ctrl_i(ctrl), .rd_data_i(rd_data),
      .rd_line_o(rd_line_o), .rd_ready_o(rd_ready_o), .rd_ready_i(rd_ready_i),
      .ram_en_o(rd_en), .ram_addr_o(rd_ram_addr),
      .idle_o(rd_idle), .done_o(rd_done), .error_o(rd_error));

   // Status word, reserved bits read as zero
   assign status_o = '{wr_addr:  wr_addr,
                       rsvd_hi:  9'd0,
                       rd_idle:  rd_idle,
                       rd_error: rd_error,
                       rd_done:  rd_done,
                       rsvd_lo:  1'b0,
                       wr_idle:  wr_idle,
                       wr_error: wr_error,
                       wr_done:  wr_done};

endmodule

// ==== tests/pkt_buf_tb_ref.svh ====
// ======================================================================
// Reference functions, value check and bus driver tasks for the testbench
// ======================================================================
`ifndef PKT_BUF_TB_REF_SVH
`define PKT_BUF_TB_REF_SVH

// Expected status word from the two machine states
function automatic buf_status_t expected_status(input logic [15:0] wr_addr,
                                                input buf_state_e wr_st, input buf_state_e rd_st);
   buf_status_t s;
   s          = '0;
   s.wr_addr  = wr_addr;
   s.wr_idle  = (wr_st == IDLE);
   s.wr_done  = (wr_st == DONE);
   s.wr_error = (wr_st == ERROR);
   s.rd_idle  = (rd_st == IDLE);
   s.rd_done  = (rd_st == DONE);
   s.rd_error = 1'b0;                 // Read side never flags an error
   return s;
endfunction

// Line k of a read of len words from the out-buffer copy
function automatic fifo_line_t expected_line(input int k, input int len);
   return '{occ: 2'b00, eop: (k == len - 1), sop: (k == 0), data: out_words[k]};
endfunction

// Word n of a long packet lands here
function automatic int clip_addr(input int n);
   return (n >= DEPTH) ? DEPTH - 1 : n;
endfunction

task automatic check_value(input string name, input logic [35:0] got, input logic [35:0] exp);
   checks++;
   if (got !== exp)
   begin
      $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
   end
endtask

// Drives the control word and returns once the machines have seen go
task automatic command(input logic [15:0] len, input logic [3:0] bits);
   set_stb_i  = 1'b1;
   set_addr_i = BASE;
   set_data_i = {len, 12'd0, bits};
   @(posedge clk);
   #1;
   set_stb_i = 1'b0;
   @(posedge clk);                    // go acted on here
   #1;
endtask

// One Wishbone cycle on word index word followed by one idle cycle
task automatic wb_access(input logic we, input int word, input logic [31:0] wdata,
                         output logic [31:0] rdata);
   int waited;
   waited   = 0;
   wb_stb_i = 1'b1;
   wb_we_i  = we;
   wb_adr_i = 16'(word * 4);          // Byte address
   wb_dat_i = wdata;
   @(posedge clk);
   #1;
   while (!wb_ack_o && waited < 8)
   begin
      @(posedge clk);
      #1;
      waited++;
   end
   if (!wb_ack_o)
   begin
      $display("Wishbone acknowledge never came for word %0d", word);
      errors++;
   end
   rdata    = wb_dat_o;
   wb_stb_i = 1'b0;
   wb_we_i  = 1'b0;
   @(posedge clk);
   #1;
   check_value("wb_ack_o", wb_ack_o, 1'b0);   // Ack lasts a single cycle
endtask

`endif

// ==== tests/pkt_buf_tb.sv ====
// ======================================================================
// Packet buffer testbench: streams, Wishbone, clear and overlong packet
// ======================================================================
`timescale 1ns/1ps

module pkt_buf_tb;

   import pkt_buf_pkg::*;

   localparam logic [7:0] BASE       = 8'h20;
   localparam int         BUF_SIZE   = 9;
   localparam int         DEPTH      = 1 << BUF_SIZE;
   localparam int         MAX_PKT    = 40;
   localparam int         LONG_LEN   = DEPTH + 8;   // Runs past the top word
   localparam logic [3:0] CMD_READ   = 4'b1000;
   localparam logic [3:0] CMD_RD_CLR = 4'b0100;
   localparam logic [3:0] CMD_WRITE  = 4'b0010;
   localparam logic [3:0] CMD_WR_CLR = 4'b0001;
   // Reset, three short packets with bus traffic, the long packet and its readback
   localparam int TEST_CYCLES = 8 + 3 * MAX_PKT * 12 + LONG_LEN + DEPTH * 3 + 200;

   logic        clk = 1'b0;
   logic        wb_rst_i;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   buf_status_t status_o;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [15:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   fifo_line_t  wr_line_i;
   logic        wr_ready_i;
   logic        wr_ready_o;
   fifo_line_t  rd_line_o;
   logic        rd_ready_o;
   logic        rd_ready_i = 1'b0;
   int          errors = 0;
   int          checks = 0;
   int          sink_mode = 0;                    // 0 stalled, 1 always ready, else random
   int          rd_len = 0;
   int          rd_count = 0;
   logic [31:0] in_model  [0:DEPTH-1];            // Expected in-buffer contents
   logic [31:0] out_words [0:DEPTH-1];            // Words written to the out-buffer

   `include "pkt_buf_tb_ref.svh"

   pkt_buf_top #(.BASE(BASE), .BUF_SIZE(BUF_SIZE)) pkt_buf_top_i (.*);

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      #1;
      if (sink_mode == 0)
         rd_ready_i = 1'b0;
      else if (sink_mode == 1)
         rd_ready_i = 1'b1;
      else
         rd_ready_i = ($urandom % 4) != 0;        // About one stall in four
   end

   // Both sides are stable mid-cycle and a transfer follows on the next edge
   always @(negedge clk)
   begin
      if (!wb_rst_i && rd_ready_o && rd_ready_i)
      begin
         if (rd_count >= rd_len)
         begin
            $display("Read side sent a line past the commanded length");
            errors++;
         end
         else
            check_value("rd_line_o", rd_line_o, expected_line(rd_count, rd_len));
         rd_count++;
      end
   end

   task automatic send_line(input logic [31:0] data, input logic sop, input logic eop);
      int waited;
      waited     = 0;
      wr_line_i  = '{occ: 2'b00, eop: eop, sop: sop, data: data};
      wr_ready_i = 1'b1;
      while (!wr_ready_o && waited < 20)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!wr_ready_o)
      begin
         $display("Write side never became ready");
         errors++;
      end
      @(posedge clk);                             // Line taken on this edge
      #1;
   endtask

   task automatic send_packet(input int len);
      logic [31:0] word;
      for (int k = 0; k < len; k++)
      begin
         word                  = $urandom;
         in_model[clip_addr(k)] = word;
         send_line(word, k == 0, k == len - 1);
      end
      wr_ready_i = 1'b0;
   endtask

   // Fill the out-buffer over Wishbone and stream it back out
   task automatic stream_read(input int len, input int mode);
      logic [31:0] unused;
      int          waited;
      waited = 0;
      for (int k = 0; k < len; k++)
      begin
         out_words[k] = $urandom;
         wb_access(1'b1, k, out_words[k], unused);
      end
      rd_len    = len;
      rd_count  = 0;
      sink_mode = mode;
      command(16'(len), CMD_READ);
      while (!status_o.rd_done && waited < len * 8 + 20)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      sink_mode = 0;
      if (!status_o.rd_done || rd_count != len)
      begin
         $display("Read of %0d words ended after %0d lines", len, rd_count);
         errors++;
      end
   endtask

   initial
   begin
      logic [31:0] rdata;
      int          len1;
      void'($urandom(32'hf70b601d));
      wb_rst_i   = 1'b1;
      set_stb_i  = 1'b0;
      set_addr_i = 8'd0;
      set_data_i = 32'd0;
      wb_stb_i   = 1'b0;
      wb_we_i    = 1'b0;
      wb_adr_i   = 16'd0;
      wb_dat_i   = 32'd0;
      wr_line_i  = '0;
      wr_ready_i = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      wb_rst_i = 1'b0;
      check_value("status_o", status_o, expected_status(16'd0, IDLE, IDLE));
      check_value("wr_ready_o", wr_ready_o, 1'b0);
      check_value("rd_ready_o", rd_ready_o, 1'b0);
      check_value("wb_ack_o", wb_ack_o, 1'b0);
      // Packet in through the stream and out over Wishbone
      len1 = 2 + int'($urandom % MAX_PKT);
      command(16'd0, CMD_WRITE);
      send_packet(len1);
      check_value("status_o", status_o, expected_status(16'(len1), DONE, IDLE));
      for (int k = 0; k < len1; k++)
      begin
         wb_access(1'b0, k, 32'd0, rdata);
         check_value("wb_dat_o", rdata, in_model[k]);
      end
      stream_read(2 + int'($urandom % MAX_PKT), 1);
      check_value("status_o", status_o, expected_status(16'(len1), DONE, DONE));
      command(16'd0, CMD_RD_CLR);
      stream_read(2 + int'($urandom % MAX_PKT), 2);   // Random back-pressure
      check_value("status_o", status_o, expected_status(16'(len1), DONE, DONE));
      // Single line with sop and eop together
      command(16'd0, CMD_WR_CLR);
      command(16'd0, CMD_WRITE);
      send_packet(1);
      check_value("status_o", status_o, expected_status(16'd1, ERROR, DONE));
      // Clear both machines in the middle of their work
      command(16'd0, CMD_WR_CLR | CMD_RD_CLR);
      check_value("status_o", status_o, expected_status(16'd1, IDLE, IDLE));
      command(16'd16, CMD_WRITE | CMD_READ);
      send_line($urandom, 1'b1, 1'b0);
      send_line($urandom, 1'b0, 1'b0);
      wr_ready_i = 1'b0;
      check_value("rd_ready_o", rd_ready_o, 1'b1);      // Read stalled by the sink
      command(16'd0, CMD_WR_CLR | CMD_RD_CLR);
      repeat (3)
      begin
         check_value("status_o", status_o, expected_status(16'd2, IDLE, IDLE));
         check_value("wr_ready_o", wr_ready_o, 1'b0);
         check_value("rd_ready_o", rd_ready_o, 1'b0);
         @(posedge clk);
         #1;
      end
      // Overlong packet piles its tail into the top word
      command(16'd0, CMD_WRITE);
      send_packet(LONG_LEN);
      check_value("status_o", status_o, expected_status(16'(LONG_LEN), DONE, IDLE));
      for (int k = 0; k < DEPTH; k++)
      begin
         wb_access(1'b0, k, 32'd0, rdata);
         check_value("wb_dat_o", rdata, in_model[k]);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   initial
   begin
      #(TEST_CYCLES * 100 * 2);
      $display("Watchdog expired before the tests finished");
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("tests failed");
      $finish;
   end

endmodule

// ==== pkt_buf.f ====
+incdir+tests
verilog/pkt_buf_pkg.sv
verilog/setting_reg.sv
verilog/ram_2port.sv
verilog/buf_write_fsm.sv
verilog/buf_ram_bank.sv
verilog/buf_read_fsm.sv
verilog/pkt_buf_top.sv
tests/pkt_buf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the packet buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pkt_buf_tb -f pkt_buf.f -o pkt_buf_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi
./obj_dir/pkt_buf_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
if grep -q "all tests passed" sim.log; then
   exit 0
fi
exit 1
